// ==== source/board_io_pkg.sv ====
// Pad geometry for the flash and I2C glue; widths are fixed by the board and not parameters
package board_io_pkg;

    // Parallel configuration flash
    localparam int FLASH_DQ_WIDTH = 16;
    localparam int FLASH_ADDR_WIDTH = 23;

    // Open-drain I2C lines, one bit per line in every I2C vector
    localparam int I2C_LINES = 5;

    localparam int I2C_SFP_SCL = 0;
    localparam int I2C_SFP1_SDA = 1;
    localparam int I2C_SFP2_SDA = 2;
    localparam int I2C_EEPROM_SCL = 3;
    localparam int I2C_EEPROM_SDA = 4;

    // SFP presence and loss-of-signal, two per cage
    localparam int STATUS_WIDTH = 4;

    // Flip-flops per synchronized input bit
    localparam int SYNC_STAGES = 2;

endpackage

// ==== source/icap_pkg.sv ====
// Reprogram command stream for the internal configuration port; type-1 write to CMD only
package icap_pkg;

    localparam int ICAP_WORD_WIDTH = 32;

    // Raw words of the reboot stream
    localparam logic [ICAP_WORD_WIDTH-1:0] ICAP_DUMMY = 32'hFFFF_FFFF;
    localparam logic [ICAP_WORD_WIDTH-1:0] ICAP_SYNC = 32'hAA99_5566;
    localparam logic [ICAP_WORD_WIDTH-1:0] ICAP_NOOP = 32'h2000_0000;
    localparam logic [ICAP_WORD_WIDTH-1:0] ICAP_IPROG = 32'h0000_000F;

    // Type-1 packet header fields
    localparam logic [2:0] ICAP_HDR_TYPE1 = 3'b001;
    localparam logic [1:0] ICAP_OP_WRITE = 2'b10;
    localparam logic [13:0] ICAP_REG_CMD = 14'd4;
    localparam logic [10:0] ICAP_CMD_WORDS = 11'd1;

    // Write one word to the command register
    localparam logic [ICAP_WORD_WIDTH-1:0] ICAP_WRITE_CMD =
        {ICAP_HDR_TYPE1, ICAP_OP_WRITE, ICAP_REG_CMD, 2'b00, ICAP_CMD_WORDS};

    // Dummy, sync, no-op, write, reprogram, no-op
    localparam int ICAP_SEQ_LEN = 6;
    localparam int ICAP_STATE_WIDTH = $clog2(ICAP_SEQ_LEN + 1);

    localparam int BOOT_SYNC_STAGES = 3;

    // One configuration word, raw or as a type-1 header
    typedef union packed {
        logic [ICAP_WORD_WIDTH-1:0] raw;
        struct packed {
            logic [2:0]  hdr_type;
            logic [1:0]  opcode;
            logic [13:0] reg_addr;
            logic [1:0]  rsvd;
            logic [10:0] word_count;
        } hdr;
    } icap_word_u;

endpackage

// ==== source/input_sync.sv ====
// Plain flip-flop chain per bit; bits are not sampled coherently, so multi-bit inputs may skew
module input_sync
    import board_io_pkg::*;
#(
    parameter int WIDTH = 1
) (
    input  logic             reset_i,
    input  logic             pcie_user_clk,
    input  logic [WIDTH-1:0] async_i,
    output logic [WIDTH-1:0] sync_o
);

    logic [SYNC_STAGES-1:0][WIDTH-1:0] sync_reg;

    always_ff @(posedge pcie_user_clk) begin
        if (reset_i) begin
            sync_reg <= '0;
        end else begin
            sync_reg[0] <= async_i;
            for (int s = 1; s < SYNC_STAGES; s++) begin
                sync_reg[s] <= sync_reg[s-1];
            end
        end
    end

    // Last stage is the only one safe to use
    assign sync_o = sync_reg[SYNC_STAGES-1];

endmodule

// ==== source/io_pad_ctrl.sv ====
// Pads split into value, enable and input ports; the board-level tristate buffers live outside
module io_pad_ctrl
    import board_io_pkg::*;
(
    input  logic                        pcie_user_clk,
    input  logic                        reset_i,

    input  logic [FLASH_DQ_WIDTH-1:0]   flash_dq_core_i,
    input  logic                        flash_dq_oe_core_i,
    input  logic [FLASH_ADDR_WIDTH-1:0] flash_addr_core_i,
    input  logic                        flash_region_core_i,
    input  logic                        flash_region_oe_core_i,
    input  logic                        flash_ce_n_core_i,
    input  logic                        flash_oe_n_core_i,
    input  logic                        flash_we_n_core_i,
    input  logic                        flash_adv_n_core_i,
    input  logic [I2C_LINES-1:0]        i2c_o_core_i,
    input  logic [I2C_LINES-1:0]        i2c_t_core_i,

    output logic [FLASH_DQ_WIDTH-1:0]   flash_dq_o,
    output logic                        flash_dq_oe_o,
    output logic [FLASH_ADDR_WIDTH-1:0] flash_addr_o,
    output logic                        flash_region_o,
    output logic                        flash_region_oe_o,
    output logic                        flash_ce_n_o,
    output logic                        flash_oe_n_o,
    output logic                        flash_we_n_o,
    output logic                        flash_adv_n_o,
    output logic [I2C_LINES-1:0]        i2c_drive_low_o,

    input  logic [FLASH_DQ_WIDTH-1:0]   flash_dq_i,
    input  logic [I2C_LINES-1:0]        i2c_i,
    input  logic [STATUS_WIDTH-1:0]     status_i,

    output logic [FLASH_DQ_WIDTH-1:0]   flash_dq_core_o,
    output logic [I2C_LINES-1:0]        i2c_core_o,
    output logic [STATUS_WIDTH-1:0]     status_core_o
);

    logic [I2C_LINES-1:0] i2c_o_reg;
    logic [I2C_LINES-1:0] i2c_t_reg;

    // Strobes and enables, parked with the flash deselected and I2C released
    always_ff @(posedge pcie_user_clk) begin
        if (reset_i) begin
            flash_dq_oe_o <= 1'b0;
            flash_region_oe_o <= 1'b0;
            flash_ce_n_o <= 1'b1;
            flash_oe_n_o <= 1'b1;
            flash_we_n_o <= 1'b1;
            flash_adv_n_o <= 1'b1;
            i2c_t_reg <= '1;
        end else begin
            flash_dq_oe_o <= flash_dq_oe_core_i;
            flash_region_oe_o <= flash_region_oe_core_i;
            flash_ce_n_o <= flash_ce_n_core_i;
            flash_oe_n_o <= flash_oe_n_core_i;
            flash_we_n_o <= flash_we_n_core_i;
            flash_adv_n_o <= flash_adv_n_core_i;
            i2c_t_reg <= i2c_t_core_i;
        end
    end

    // Data values, only meaningful behind their enables
    always_ff @(posedge pcie_user_clk) begin
        flash_dq_o <= flash_dq_core_i;
        flash_addr_o <= flash_addr_core_i;
        flash_region_o <= flash_region_core_i;
        i2c_o_reg <= i2c_o_core_i;
    end

    // Pull low only when enabled and driving zero
    assign i2c_drive_low_o[I2C_SFP_SCL] = ~i2c_t_reg[I2C_SFP_SCL] & ~i2c_o_reg[I2C_SFP_SCL];
    assign i2c_drive_low_o[I2C_SFP1_SDA] = ~i2c_t_reg[I2C_SFP1_SDA] & ~i2c_o_reg[I2C_SFP1_SDA];
    assign i2c_drive_low_o[I2C_SFP2_SDA] = ~i2c_t_reg[I2C_SFP2_SDA] & ~i2c_o_reg[I2C_SFP2_SDA];
    assign i2c_drive_low_o[I2C_EEPROM_SCL] =
        ~i2c_t_reg[I2C_EEPROM_SCL] & ~i2c_o_reg[I2C_EEPROM_SCL];
    assign i2c_drive_low_o[I2C_EEPROM_SDA] =
        ~i2c_t_reg[I2C_EEPROM_SDA] & ~i2c_o_reg[I2C_EEPROM_SDA];

    input_sync #(
        .WIDTH(FLASH_DQ_WIDTH)
    ) flash_sync_inst (
        .reset_i(reset_i),
        .pcie_user_clk(pcie_user_clk),
        .async_i(flash_dq_i),
        .sync_o(flash_dq_core_o)
    );

    // I2C readback and SFP status share one bank
    input_sync #(
        .WIDTH(I2C_LINES + STATUS_WIDTH)
    ) io_sync_inst (
        .reset_i(reset_i),
        .pcie_user_clk(pcie_user_clk),
        .async_i({status_i, i2c_i}),
        .sync_o({status_core_o, i2c_core_o})
    );

endmodule

// ==== source/icap_reboot_seq.sv ====
// Write-only reboot stream; icap_avail_i is checked at start only, a running sequence always ends
module icap_reboot_seq
    import icap_pkg::*;
(
    input  logic                       pcie_user_clk,
    input  logic                       reset_i,
    input  logic                       boot_req_i,
    input  logic                       icap_avail_i,
    output logic                       icap_csib_o,
    output logic                       icap_rdwrb_o,
    output logic [ICAP_WORD_WIDTH-1:0] icap_di_o
);

    logic [BOOT_SYNC_STAGES-1:0] boot_sync;
    logic                        boot_req_sync;
    logic [ICAP_STATE_WIDTH-1:0] state;
    logic                        seq_free;
    icap_word_u                  word_reg;

    always_ff @(posedge pcie_user_clk) begin
        if (reset_i) begin
            boot_sync <= '0;
        end else begin
            boot_sync <= {boot_sync[BOOT_SYNC_STAGES-2:0], boot_req_i};
        end
    end

    assign boot_req_sync = boot_sync[BOOT_SYNC_STAGES-1];

    // Idle, or the last word is on the port and a new run may follow back to back
    assign seq_free = (state == '0) || (state == ICAP_STATE_WIDTH'(ICAP_SEQ_LEN));

    // State n means word n-1 of the stream is being presented
    always_ff @(posedge pcie_user_clk) begin
        if (reset_i) begin
            state <= '0;
            icap_csib_o <= 1'b1;
            word_reg.raw <= ICAP_DUMMY;
        end else if (seq_free) begin
            word_reg.raw <= ICAP_DUMMY;
            if (boot_req_sync && icap_avail_i) begin
                state <= ICAP_STATE_WIDTH'(1);
                icap_csib_o <= 1'b0;
            end else begin
                state <= '0;
                icap_csib_o <= 1'b1;
            end
        end else begin
            state <= state + 1'b1;
            icap_csib_o <= 1'b0;
            case (state)
                ICAP_STATE_WIDTH'(1): begin
                    word_reg.raw <= ICAP_SYNC;
                end
                ICAP_STATE_WIDTH'(3): begin
                    // Type-1 write of one word to CMD
                    word_reg.hdr.hdr_type <= ICAP_HDR_TYPE1;
                    word_reg.hdr.opcode <= ICAP_OP_WRITE;
                    word_reg.hdr.reg_addr <= ICAP_REG_CMD;
                    word_reg.hdr.rsvd <= 2'b00;
                    word_reg.hdr.word_count <= ICAP_CMD_WORDS;
                end
                ICAP_STATE_WIDTH'(4): begin
                    word_reg.raw <= ICAP_IPROG;
                end
                default: begin
                    word_reg.raw <= ICAP_NOOP;
                end
            endcase
        end
    end

    // Port only ever written
    assign icap_rdwrb_o = 1'b0;

    // Config port takes each byte MSB-first on bit 0
    for (genvar b = 0; b < ICAP_WORD_WIDTH / 8; b++) begin : g_byte
        for (genvar i = 0; i < 8; i++) begin : g_bit
            assign icap_di_o[8*b + i] = word_reg.raw[8*b + 7 - i];
        end
    end

endmodule

// ==== source/board_io_top.sv ====
// Board glue on pcie_user_clk only; reset_i must already be synchronous to that clock
module board_io_top
    import board_io_pkg::*;
    import icap_pkg::*;
(
    input  logic                        pcie_user_clk,
    input  logic                        reset_i,

    input  logic [FLASH_DQ_WIDTH-1:0]   flash_dq_core_i,
    input  logic                        flash_dq_oe_core_i,
    input  logic [FLASH_ADDR_WIDTH-1:0] flash_addr_core_i,
    input  logic                        flash_region_core_i,
    input  logic                        flash_region_oe_core_i,
    input  logic                        flash_ce_n_core_i,
    input  logic                        flash_oe_n_core_i,
    input  logic                        flash_we_n_core_i,
    input  logic                        flash_adv_n_core_i,
    input  logic [I2C_LINES-1:0]        i2c_o_core_i,
    input  logic [I2C_LINES-1:0]        i2c_t_core_i,

    output logic [FLASH_DQ_WIDTH-1:0]   flash_dq_o,
    output logic                        flash_dq_oe_o,
    output logic [FLASH_ADDR_WIDTH-1:0] flash_addr_o,
    output logic                        flash_region_o,
    output logic                        flash_region_oe_o,
    output logic                        flash_ce_n_o,
    output logic                        flash_oe_n_o,
    output logic                        flash_we_n_o,
    output logic                        flash_adv_n_o,
    output logic [I2C_LINES-1:0]        i2c_drive_low_o,

    input  logic [FLASH_DQ_WIDTH-1:0]   flash_dq_i,
    input  logic [I2C_LINES-1:0]        i2c_i,
    input  logic [STATUS_WIDTH-1:0]     status_i,
    output logic [FLASH_DQ_WIDTH-1:0]   flash_dq_core_o,
    output logic [I2C_LINES-1:0]        i2c_core_o,
    output logic [STATUS_WIDTH-1:0]     status_core_o,

    input  logic                        boot_req_i,
    input  logic                        icap_avail_i,
    output logic                        icap_csib_o,
    output logic                        icap_rdwrb_o,
    output logic [ICAP_WORD_WIDTH-1:0]  icap_di_o
);

    io_pad_ctrl pad_ctrl_inst (
        .pcie_user_clk(pcie_user_clk),
        .reset_i(reset_i),
        .flash_dq_core_i(flash_dq_core_i),
        .flash_dq_oe_core_i(flash_dq_oe_core_i),
        .flash_addr_core_i(flash_addr_core_i),
        .flash_region_core_i(flash_region_core_i),
        .flash_region_oe_core_i(flash_region_oe_core_i),
        .flash_ce_n_core_i(flash_ce_n_core_i),
        .flash_oe_n_core_i(flash_oe_n_core_i),
        .flash_we_n_core_i(flash_we_n_core_i),
        .flash_adv_n_core_i(flash_adv_n_core_i),
        .i2c_o_core_i(i2c_o_core_i),
        .i2c_t_core_i(i2c_t_core_i),
        .flash_dq_o(flash_dq_o),
        .flash_dq_oe_o(flash_dq_oe_o),
        .flash_addr_o(flash_addr_o),
        .flash_region_o(flash_region_o),
        .flash_region_oe_o(flash_region_oe_o),
        .flash_ce_n_o(flash_ce_n_o),
        .flash_oe_n_o(flash_oe_n_o),
        .flash_we_n_o(flash_we_n_o),
        .flash_adv_n_o(flash_adv_n_o),
        .i2c_drive_low_o(i2c_drive_low_o),
        .flash_dq_i(flash_dq_i),
        .i2c_i(i2c_i),
        .status_i(status_i),
        .flash_dq_core_o(flash_dq_core_o),
        .i2c_core_o(i2c_core_o),
        .status_core_o(status_core_o)
    );

    icap_reboot_seq reboot_seq_inst (
        .pcie_user_clk(pcie_user_clk),
        .reset_i(reset_i),
        .boot_req_i(boot_req_i),
        .icap_avail_i(icap_avail_i),
        .icap_csib_o(icap_csib_o),
        .icap_rdwrb_o(icap_rdwrb_o),
        .icap_di_o(icap_di_o)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
// Clock period is 4 time units; reset is released on a falling edge after RESET_CYCLES rising edges
module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic pcie_user_clk,
    output logic reset_o
);

    initial begin
        pcie_user_clk = 1'b0;
        forever #2 pcie_user_clk = ~pcie_user_clk;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge pcie_user_clk);
        @(negedge pcie_user_clk);
        reset_o = 1'b0;
    end

endmodule

// ==== tests/tb_checker.sv ====
// Models the pad pipelines and the reboot stream from the port timing; compares on falling edges
module tb_checker
    import board_io_pkg::*;
    import icap_pkg::*;
(
    input  logic                        pcie_user_clk,
    input  logic                        reset_i,
    input  logic [FLASH_DQ_WIDTH-1:0]   flash_dq_core_i,
    input  logic                        flash_dq_oe_core_i,
    input  logic [FLASH_ADDR_WIDTH-1:0] flash_addr_core_i,
    input  logic                        flash_region_core_i,
    input  logic                        flash_region_oe_core_i,
    input  logic                        flash_ce_n_core_i,
    input  logic                        flash_oe_n_core_i,
    input  logic                        flash_we_n_core_i,
    input  logic                        flash_adv_n_core_i,
    input  logic [I2C_LINES-1:0]        i2c_o_core_i,
    input  logic [I2C_LINES-1:0]        i2c_t_core_i,
    input  logic [FLASH_DQ_WIDTH-1:0]   flash_dq_o,
    input  logic                        flash_dq_oe_o,
    input  logic [FLASH_ADDR_WIDTH-1:0] flash_addr_o,
    input  logic                        flash_region_o,
    input  logic                        flash_region_oe_o,
    input  logic                        flash_ce_n_o,
    input  logic                        flash_oe_n_o,
    input  logic                        flash_we_n_o,
    input  logic                        flash_adv_n_o,
    input  logic [I2C_LINES-1:0]        i2c_drive_low_o,
    input  logic [FLASH_DQ_WIDTH-1:0]   flash_dq_i,
    input  logic [I2C_LINES-1:0]        i2c_i,
    input  logic [STATUS_WIDTH-1:0]     status_i,
    input  logic [FLASH_DQ_WIDTH-1:0]   flash_dq_core_o,
    input  logic [I2C_LINES-1:0]        i2c_core_o,
    input  logic [STATUS_WIDTH-1:0]     status_core_o,
    input  logic                        boot_req_i,
    input  logic                        icap_avail_i,
    input  logic                        icap_csib_o,
    input  logic                        icap_rdwrb_o,
    input  logic [ICAP_WORD_WIDTH-1:0]  icap_di_o,
    output int                          error_count_o,
    output int                          check_count_o
);

    // One-cycle copies of the core side
    logic [FLASH_DQ_WIDTH-1:0]   exp_dq;
    logic [FLASH_ADDR_WIDTH-1:0] exp_addr;
    logic [5:0]                  exp_ctrl;
    logic                        exp_region;
    logic [I2C_LINES-1:0]        exp_i2c_o;
    logic [I2C_LINES-1:0]        exp_i2c_t;
    logic [I2C_LINES-1:0]        exp_drive_low;

    // Two-cycle copies of the board inputs
    logic [FLASH_DQ_WIDTH-1:0]          dq_d1;
    logic [FLASH_DQ_WIDTH-1:0]          dq_d2;
    logic [I2C_LINES+STATUS_WIDTH-1:0]  io_d1;
    logic [I2C_LINES+STATUS_WIDTH-1:0]  io_d2;

    logic [BOOT_SYNC_STAGES-1:0] req_hist;
    int                          seq_idx;
    logic                        primed = 1'b0;

    initial begin
        error_count_o = 0;
        check_count_o = 0;
    end

    // Expected port word for stream position idx, each byte bit-reversed
    function automatic logic [ICAP_WORD_WIDTH-1:0] expected_icap_word(input int idx);
        logic [ICAP_WORD_WIDTH-1:0] word;
        logic [ICAP_WORD_WIDTH-1:0] swapped;
        case (idx)
            0: word = 32'hFFFF_FFFF;
            1: word = 32'hAA99_5566;
            // Type-1 write, register 4, one word
            3: word = 32'h3000_8001;
            4: word = 32'h0000_000F;
            default: word = 32'h2000_0000;
        endcase
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < 8; i++) begin
                swapped[8*b + i] = word[8*b + 7 - i];
            end
        end
        return swapped;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count_o++;
        if (got !== exp) begin
            error_count_o++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h at time %0t", name, got, exp, $time);
        end
    endtask

    assign exp_drive_low = ~exp_i2c_t & ~exp_i2c_o;

    always @(posedge pcie_user_clk) begin
        exp_dq <= flash_dq_core_i;
        exp_addr <= flash_addr_core_i;
        exp_region <= flash_region_core_i;
        exp_i2c_o <= i2c_o_core_i;
        if (reset_i) begin
            primed <= 1'b1;
            // dq_oe, region_oe, ce_n, oe_n, we_n, adv_n
            exp_ctrl <= 6'b00_1111;
            exp_i2c_t <= '1;
            dq_d1 <= '0;
            dq_d2 <= '0;
            io_d1 <= '0;
            io_d2 <= '0;
            req_hist <= '0;
            seq_idx <= 0;
        end else begin
            exp_ctrl <= {flash_dq_oe_core_i, flash_region_oe_core_i, flash_ce_n_core_i,
                         flash_oe_n_core_i, flash_we_n_core_i, flash_adv_n_core_i};
            exp_i2c_t <= i2c_t_core_i;
            dq_d1 <= flash_dq_i;
            dq_d2 <= dq_d1;
            io_d1 <= {status_i, i2c_i};
            io_d2 <= io_d1;
            req_hist <= {req_hist[BOOT_SYNC_STAGES-2:0], boot_req_i};
            // A run may restart while its last word is on the port
            if (seq_idx == 0 || seq_idx == ICAP_SEQ_LEN) begin
                seq_idx <= (req_hist[BOOT_SYNC_STAGES-1] && icap_avail_i) ? 1 : 0;
            end else begin
                seq_idx <= seq_idx + 1;
            end
        end
    end

    always @(negedge pcie_user_clk) begin
        if (primed) begin
            compare_value("flash_dq_o", 32'(flash_dq_o), 32'(exp_dq));
            compare_value("flash_addr_o", 32'(flash_addr_o), 32'(exp_addr));
            compare_value("flash_region_o", 32'(flash_region_o), 32'(exp_region));
            compare_value("flash_dq_oe_o", 32'(flash_dq_oe_o), 32'(exp_ctrl[5]));
            compare_value("flash_region_oe_o", 32'(flash_region_oe_o), 32'(exp_ctrl[4]));
            compare_value("flash_ce_n_o", 32'(flash_ce_n_o), 32'(exp_ctrl[3]));
            compare_value("flash_oe_n_o", 32'(flash_oe_n_o), 32'(exp_ctrl[2]));
            compare_value("flash_we_n_o", 32'(flash_we_n_o), 32'(exp_ctrl[1]));
            compare_value("flash_adv_n_o", 32'(flash_adv_n_o), 32'(exp_ctrl[0]));
            compare_value("i2c_drive_low_o", 32'(i2c_drive_low_o), 32'(exp_drive_low));
            compare_value("flash_dq_core_o", 32'(flash_dq_core_o), 32'(dq_d2));
            compare_value("i2c_core_o", 32'(i2c_core_o), 32'(io_d2[I2C_LINES-1:0]));
            compare_value("status_core_o", 32'(status_core_o),
                          32'(io_d2[I2C_LINES+STATUS_WIDTH-1:I2C_LINES]));
            compare_value("icap_csib_o", 32'(icap_csib_o), 32'(seq_idx == 0));
            compare_value("icap_rdwrb_o", 32'(icap_rdwrb_o), 32'h0);
            // Idle word is the all-ones dummy
            compare_value("icap_di_o", icap_di_o,
                          (seq_idx == 0) ? 32'hFFFF_FFFF : expected_icap_word(seq_idx - 1));
        end
    end

endmodule

// ==== tests/tb_board_io.sv ====
// Stimulus changes on falling edges only; the run is bounded by a cycle counter
module tb_board_io
    import board_io_pkg::*;
    import icap_pkg::*;
;

    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES = 8;
    localparam int PAD_CYCLES = 200;
    localparam int BOOT_CYCLES = 90;
    localparam int STIM_CYCLES = RESET_CYCLES + IDLE_CYCLES + PAD_CYCLES + BOOT_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

    logic                        pcie_user_clk;
    logic                        reset_i;
    logic [FLASH_DQ_WIDTH-1:0]   flash_dq_core_i;
    logic                        flash_dq_oe_core_i;
    logic [FLASH_ADDR_WIDTH-1:0] flash_addr_core_i;
    logic                        flash_region_core_i;
    logic                        flash_region_oe_core_i;
    logic                        flash_ce_n_core_i;
    logic                        flash_oe_n_core_i;
    logic                        flash_we_n_core_i;
    logic                        flash_adv_n_core_i;
    logic [I2C_LINES-1:0]        i2c_o_core_i;
    logic [I2C_LINES-1:0]        i2c_t_core_i;
    logic [FLASH_DQ_WIDTH-1:0]   flash_dq_o;
    logic                        flash_dq_oe_o;
    logic [FLASH_ADDR_WIDTH-1:0] flash_addr_o;
    logic                        flash_region_o;
    logic                        flash_region_oe_o;
    logic                        flash_ce_n_o;
    logic                        flash_oe_n_o;
    logic                        flash_we_n_o;
    logic                        flash_adv_n_o;
    logic [I2C_LINES-1:0]        i2c_drive_low_o;
    logic [FLASH_DQ_WIDTH-1:0]   flash_dq_i;
    logic [I2C_LINES-1:0]        i2c_i;
    logic [STATUS_WIDTH-1:0]     status_i;
    logic [FLASH_DQ_WIDTH-1:0]   flash_dq_core_o;
    logic [I2C_LINES-1:0]        i2c_core_o;
    logic [STATUS_WIDTH-1:0]     status_core_o;
    logic                        boot_req_i;
    logic                        icap_avail_i;
    logic                        icap_csib_o;
    logic                        icap_rdwrb_o;
    logic [ICAP_WORD_WIDTH-1:0]  icap_di_o;

    int error_count;
    int check_count;
    int wait_errors = 0;
    int cycle_count = 0;
    int seed = 34137;

    tb_clock_gen #(
        .RESET_CYCLES(RESET_CYCLES)
    ) clock_gen_inst (
        .pcie_user_clk(pcie_user_clk),
        .reset_o(reset_i)
    );

    board_io_top uut (.*);

    tb_checker checker_inst (
        .error_count_o(error_count),
        .check_count_o(check_count),
        .*
    );

    task automatic drive_random_pads();
        flash_dq_core_i = FLASH_DQ_WIDTH'($random(seed));
        flash_dq_oe_core_i = 1'($random(seed));
        flash_addr_core_i = FLASH_ADDR_WIDTH'($random(seed));
        flash_region_core_i = 1'($random(seed));
        flash_region_oe_core_i = 1'($random(seed));
        flash_ce_n_core_i = 1'($random(seed));
        flash_oe_n_core_i = 1'($random(seed));
        flash_we_n_core_i = 1'($random(seed));
        flash_adv_n_core_i = 1'($random(seed));
        i2c_o_core_i = I2C_LINES'($random(seed));
        i2c_t_core_i = I2C_LINES'($random(seed));
        flash_dq_i = FLASH_DQ_WIDTH'($random(seed));
        i2c_i = I2C_LINES'($random(seed));
        status_i = STATUS_WIDTH'($random(seed));
    endtask

    task automatic wait_for_chip_select(input logic level, input int limit);
        int n;
        n = 0;
        while (icap_csib_o !== level && n < limit) begin
            @(negedge pcie_user_clk);
            n++;
        end
        if (icap_csib_o !== level) begin
            wait_errors++;
            $display("icap_csib_o did not reach %0b within %0d cycles", level, limit);
        end
    endtask

    always @(posedge pcie_user_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        // Quiet core side: flash deselected, I2C released
        flash_dq_core_i = '0;
        flash_dq_oe_core_i = 1'b0;
        flash_addr_core_i = '0;
        flash_region_core_i = 1'b0;
        flash_region_oe_core_i = 1'b0;
        flash_ce_n_core_i = 1'b1;
        flash_oe_n_core_i = 1'b1;
        flash_we_n_core_i = 1'b1;
        flash_adv_n_core_i = 1'b1;
        i2c_o_core_i = '1;
        i2c_t_core_i = '1;
        flash_dq_i = '0;
        i2c_i = '1;
        status_i = '0;
        boot_req_i = 1'b0;
        icap_avail_i = 1'b1;

        @(negedge pcie_user_clk);
        while (reset_i) begin
            @(negedge pcie_user_clk);
        end
        repeat (IDLE_CYCLES) @(negedge pcie_user_clk);

        repeat (PAD_CYCLES) begin
            @(negedge pcie_user_clk);
            drive_random_pads();
        end

        // Single-cycle request with the port available
        @(negedge pcie_user_clk);
        boot_req_i = 1'b1;
        @(negedge pcie_user_clk);
        boot_req_i = 1'b0;
        wait_for_chip_select(1'b0, 8);
        wait_for_chip_select(1'b1, 10);

        // Held request runs back to back
        boot_req_i = 1'b1;
        repeat (10) @(negedge pcie_user_clk);
        boot_req_i = 1'b0;
        wait_for_chip_select(1'b1, 20);

        // Port busy, then freed; dropped again mid-run
        icap_avail_i = 1'b0;
        boot_req_i = 1'b1;
        repeat (12) @(negedge pcie_user_clk);
        icap_avail_i = 1'b1;
        wait_for_chip_select(1'b0, 4);
        repeat (2) @(negedge pcie_user_clk);
        icap_avail_i = 1'b0;
        boot_req_i = 1'b0;
        wait_for_chip_select(1'b1, 10);
        repeat (6) @(negedge pcie_user_clk);

        $display("Checks: %0d, value errors: %0d, handshake errors: %0d",
                 check_count, error_count, wait_errors);
        if (error_count == 0 && wait_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
source/board_io_pkg.sv
source/icap_pkg.sv
source/input_sync.sv
source/io_pad_ctrl.sv
source/icap_reboot_seq.sv
source/board_io_top.sv
tests/tb_clock_gen.sv
tests/tb_checker.sv
tests/tb_board_io.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_board_io
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_MSG ?= *** PASSED ***

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
